/* common/glay_filter_pkg.sv */
// --------------------------------------------------
// Shared sizes and types of the filter engine
// All widths are fixed here, and only the FIFO depth
// can be overridden per instance
// --------------------------------------------------

package glay_filter_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam int data_w      = 32;
    localparam int route_w     = 8;
    localparam int seq_id_w    = 8;
    localparam int hops_w      = 4;
    localparam int fifo_depth  = 16;
    // Must stay below the depth to absorb packets in flight
    localparam int prog_thresh = 8;

    typedef enum logic [1:0] {
        cmp_eq = 2'd0,
        cmp_ne = 2'd1,
        cmp_lt = 2'd2,
        cmp_gt = 2'd3
    } cmp_op_e;

    typedef enum logic [1:0] {
        st_reset = 2'd0,
        st_idle  = 2'd1,
        st_busy  = 2'd2,
        st_pause = 2'd3
    } ctrl_state_e;

    // One data word, read as unsigned or as two's complement
    typedef union packed {
        logic        [data_w-1:0] u;
        logic signed [data_w-1:0] s;
    } data_word_u;

    typedef struct packed {
        logic [route_w-1:0]  dest;
        logic [route_w-1:0]  src;
        logic [seq_id_w-1:0] seq_id;
        logic                seq_done;
        logic [hops_w-1:0]   hops;
    } route_meta_s;

    typedef struct packed {
        data_word_u  data;
        route_meta_s meta;
    } engine_pkt_s;

    typedef struct packed {
        cmp_op_e            op;
        logic               cmp_signed;
        data_word_u         constant;
        logic               filter_invert;
        logic               break_en;
        logic               break_invert;
        logic [route_w-1:0] filter_route;
    } filter_cfg_s;

    // Compare stage output
    typedef struct packed {
        logic        valid;
        engine_pkt_s pkt;
        logic        cmp;
    } alu_result_s;

endpackage : glay_filter_pkg

/* logic/packet_fifo.sv */
// --------------------------------------------------
// First-word-fall-through FIFO, depth of 2 or more
// Push when full and pop when empty are ignored
// not_full is registered, low during reset
// --------------------------------------------------
`timescale 1ns/100ps

module packet_fifo #(
    parameter int depth = glay_filter_pkg::fifo_depth
) (
    input  logic                        ap_clk,
    input  logic                        areset_generator,
    input  logic                        push,
    input  glay_filter_pkg::engine_pkt_s push_data,
    input  logic                        pop,
    output glay_filter_pkg::engine_pkt_s head_data,
    output logic                        not_empty,
    output logic                        not_full,
    output logic                        prog_full
);
    import glay_filter_pkg::*;

    localparam int addr_w  = $clog2(depth);
    localparam int count_w = $clog2(depth + 1);
    localparam logic [count_w-1:0] depth_c  = count_w'(depth);
    localparam logic [count_w-1:0] thresh_c = count_w'(prog_thresh);
    localparam logic [addr_w-1:0]  last_c   = addr_w'(depth - 1);

    engine_pkt_s         mem [depth];
    logic [addr_w-1:0]   wr_ptr_q;
    logic [addr_w-1:0]   rd_ptr_q;
    logic [count_w-1:0]  count_q;
    logic [count_w-1:0]  count_d;
    logic                do_push;
    logic                do_pop;

    always_comb begin
        do_push = push & (count_q != depth_c);
        do_pop  = pop & (count_q != '0);
        count_d = count_q;
        case ({do_push, do_pop})
            2'b10:   count_d = count_q + 1'b1;
            2'b01:   count_d = count_q - 1'b1;
            default: count_d = count_q;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            not_full <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == last_c) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == last_c) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q  <= count_d;
            not_full <= (count_d != depth_c);
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

    assign head_data = mem[rd_ptr_q];
    assign not_empty = (count_q != '0);
    assign prog_full = (count_q >= thresh_c);

endmodule : packet_fifo

/* logic/filter_engine_ctrl.sv */
// --------------------------------------------------
// One configuration per reset, cfg_ready high from
// reset until the handshake
// Pop is combinational from the FIFO flags
// --------------------------------------------------
`timescale 1ns/100ps

module filter_engine_ctrl (
    input  logic                        ap_clk,
    input  logic                        areset_generator,
    input  logic                        cfg_valid,
    input  glay_filter_pkg::filter_cfg_s cfg_data,
    output logic                        cfg_ready,
    output glay_filter_pkg::filter_cfg_s cfg,
    input  logic                        in_not_empty,
    input  logic                        out_prog_full,
    input  logic                        in_empty,
    input  logic                        out_empty,
    input  logic                        flow_busy,
    output logic                        pop,
    output logic                        done
);
    import glay_filter_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        cfg_fire;
    logic        configured;

    assign cfg_fire   = cfg_valid & cfg_ready;
    assign configured = ~cfg_ready;

    // --------------------------------------------------
    // Configuration capture
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cfg_ready <= 1'b1;
        end else if (cfg_fire) begin
            cfg_ready <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (cfg_fire) begin
            cfg <= cfg_data;
        end
    end

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_reset: state_d = st_idle;
            st_idle: begin
                if (configured) begin
                    state_d = st_busy;
                end
            end
            st_busy: begin
                if (out_prog_full) begin
                    state_d = st_pause;
                end
            end
            st_pause: begin
                if (!out_prog_full) begin
                    state_d = st_busy;
                end
            end
            default: state_d = st_reset;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state_q <= st_reset;
        end else begin
            state_q <= state_d;
        end
    end

    // Read only while the output side has room
    assign pop = (state_q == st_busy) & in_not_empty & ~out_prog_full;

    // Drained and configured
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done <= 1'b0;
        end else begin
            done <= configured & in_empty & out_empty & ~flow_busy;
        end
    end

endmodule : filter_engine_ctrl

/* filter_pipeline/filter_cond_alu.sv */
// --------------------------------------------------
// Compare stage, one cycle from pop to result
// Signed or unsigned view picked by the configuration
// --------------------------------------------------
`timescale 1ns/100ps

module filter_cond_alu (
    input  logic                        ap_clk,
    input  logic                        areset_generator,
    input  glay_filter_pkg::filter_cfg_s cfg,
    input  logic                        in_valid,
    input  glay_filter_pkg::engine_pkt_s in_pkt,
    output glay_filter_pkg::alu_result_s result
);
    import glay_filter_pkg::*;

    logic        lt;
    logic        gt;
    logic        eq;
    logic        cmp;
    logic        valid_q;
    engine_pkt_s pkt_q;
    logic        cmp_q;

    // --------------------------------------------------
    // Compare
    // --------------------------------------------------
    always_comb begin
        eq = (in_pkt.data.u == cfg.constant.u);
        if (cfg.cmp_signed) begin
            lt = (in_pkt.data.s < cfg.constant.s);
            gt = (in_pkt.data.s > cfg.constant.s);
        end else begin
            lt = (in_pkt.data.u < cfg.constant.u);
            gt = (in_pkt.data.u > cfg.constant.u);
        end
        case (cfg.op)
            cmp_eq:  cmp = eq;
            cmp_ne:  cmp = ~eq;
            cmp_lt:  cmp = lt;
            cmp_gt:  cmp = gt;
            default: cmp = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // Result register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        pkt_q <= in_pkt;
        cmp_q <= cmp;
    end

    assign result = '{valid: valid_q, pkt: pkt_q, cmp: cmp_q};

endmodule : filter_cond_alu

/* filter_pipeline/filter_flow_stage.sv */
// --------------------------------------------------
// Filter decision, route rewrite and break discard
// The packet that triggers a break is itself handled
// normally, discard ends on the next sequence-done
// --------------------------------------------------
`timescale 1ns/100ps

module filter_flow_stage (
    input  logic                        ap_clk,
    input  logic                        areset_generator,
    input  glay_filter_pkg::filter_cfg_s cfg,
    input  glay_filter_pkg::alu_result_s result,
    output logic                        push,
    output glay_filter_pkg::engine_pkt_s push_data,
    output logic                        busy
);
    import glay_filter_pkg::*;

    logic        discard_q;
    logic        keep;
    logic        break_hit;
    logic        break_end;
    engine_pkt_s routed;

    // --------------------------------------------------
    // Decisions
    // --------------------------------------------------
    assign keep = result.valid & ~discard_q & (result.cmp ^ cfg.filter_invert);

    // Break only starts outside a discard run
    assign break_hit = result.valid & ~discard_q & cfg.break_en
                     & (result.cmp ^ cfg.break_invert);

    assign break_end = result.valid & discard_q & result.pkt.meta.seq_done;

    always_comb begin
        routed           = result.pkt;
        routed.meta.dest = cfg.filter_route;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            discard_q <= 1'b0;
        end else if (break_end) begin
            discard_q <= 1'b0;
        end else if (break_hit) begin
            discard_q <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Output FIFO push
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push <= 1'b0;
        end else begin
            push <= keep;
        end
    end

    always_ff @(posedge ap_clk) begin
        push_data <= routed;
    end

    // Packet in the ALU register or waiting on the push
    assign busy = result.valid | push;

endmodule : filter_flow_stage

/* logic/glay_filter_engine.sv */
// --------------------------------------------------
// Filter engine top level
// Latency 4 cycles with empty FIFOs and no stall
// --------------------------------------------------
`timescale 1ns/100ps

module glay_filter_engine (
    input  logic                        ap_clk,
    input  logic                        areset_generator,
    input  logic                        cfg_valid,
    output logic                        cfg_ready,
    input  glay_filter_pkg::filter_cfg_s cfg_data,
    input  logic                        pkt_in_valid,
    output logic                        pkt_in_ready,
    input  glay_filter_pkg::engine_pkt_s pkt_in_data,
    output logic                        pkt_out_valid,
    input  logic                        pkt_out_ready,
    output glay_filter_pkg::engine_pkt_s pkt_out_data,
    output logic                        done
);
    import glay_filter_pkg::*;

    filter_cfg_s cfg;
    engine_pkt_s in_head;
    logic        in_not_empty;
    logic        in_pop;
    logic        out_prog_full;
    alu_result_s alu_result;
    logic        flow_push;
    engine_pkt_s flow_data;
    logic        flow_busy;

    packet_fifo u_in_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (pkt_in_valid & pkt_in_ready),
        .push_data        (pkt_in_data),
        .pop              (in_pop),
        .head_data        (in_head),
        .not_empty        (in_not_empty),
        .not_full         (pkt_in_ready),
        .prog_full        ()
    );

    filter_engine_ctrl u_ctrl (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_valid        (cfg_valid),
        .cfg_data         (cfg_data),
        .cfg_ready        (cfg_ready),
        .cfg              (cfg),
        .in_not_empty     (in_not_empty),
        .out_prog_full    (out_prog_full),
        .in_empty         (~in_not_empty),
        .out_empty        (~pkt_out_valid),
        .flow_busy        (flow_busy),
        .pop              (in_pop),
        .done             (done)
    );

    filter_cond_alu u_alu (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg              (cfg),
        .in_valid         (in_pop),
        .in_pkt           (in_head),
        .result           (alu_result)
    );

    filter_flow_stage u_flow (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg              (cfg),
        .result           (alu_result),
        .push             (flow_push),
        .push_data        (flow_data),
        .busy             (flow_busy)
    );

    packet_fifo u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (flow_push),
        .push_data        (flow_data),
        .pop              (pkt_out_ready),
        .head_data        (pkt_out_data),
        .not_empty        (pkt_out_valid),
        .not_full         (),
        .prog_full        (out_prog_full)
    );

endmodule : glay_filter_engine

/* verification/glay_filter_tb.sv */
// --------------------------------------------------
// Directed tests for the filter engine
// The DUT takes one configuration per reset, so
// every run starts with a reset
// --------------------------------------------------
`timescale 1ns/100ps

module glay_filter_tb;
    import glay_filter_pkg::*;

    localparam int wait_limit = 2000;

    logic        ap_clk;
    logic        areset_generator;
    logic        cfg_valid;
    logic        cfg_ready;
    filter_cfg_s cfg_data;
    logic        pkt_in_valid;
    logic        pkt_in_ready;
    engine_pkt_s pkt_in_data;
    logic        pkt_out_valid;
    logic        pkt_out_ready;
    engine_pkt_s pkt_out_data;
    logic        done;

    engine_pkt_s send_q[$];
    engine_pkt_s expect_q[$];
    engine_pkt_s got_q[$];
    logic [15:0] lfsr_state;
    logic        stall_seen;
    int          errors;
    int          tests_run;
    int          tests_failed;

    glay_filter_engine u_dut (.*);

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_random(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic add_packet(input logic [31:0] data, input logic seq_done);
        engine_pkt_s p;
        logic [31:0] r;
        take_random(20, r);
        p.data.u        = data;
        p.meta.dest     = r[19:12];
        p.meta.src      = r[11:4];
        p.meta.seq_id   = 8'(send_q.size());
        p.meta.seq_done = seq_done;
        p.meta.hops     = r[3:0];
        send_q.push_back(p);
    endtask

    function automatic filter_cfg_s make_cfg(input cmp_op_e op, input logic sgn,
                                             input logic [31:0] constant, input logic finv,
                                             input logic brk, input logic binv);
        filter_cfg_s c;
        c.op            = op;
        c.cmp_signed    = sgn;
        c.constant.u    = constant;
        c.filter_invert = finv;
        c.break_en      = brk;
        c.break_invert  = binv;
        c.filter_route  = 8'h3c;
        return c;
    endfunction

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic compare(input filter_cfg_s c, input logic [31:0] d);
        logic [31:0] k;
        k = c.constant.u;
        case (c.op)
            cmp_eq:  return d == k;
            cmp_ne:  return d != k;
            cmp_lt:  return c.cmp_signed ? ($signed(d) < $signed(k)) : (d < k);
            default: return c.cmp_signed ? ($signed(d) > $signed(k)) : (d > k);
        endcase
    endfunction

    task automatic build_expected(input filter_cfg_s c);
        logic        discarding;
        logic        hit;
        engine_pkt_s p;
        discarding = 1'b0;
        expect_q.delete();
        foreach (send_q[i]) begin
            p   = send_q[i];
            hit = compare(c, p.data.u);
            if (discarding) begin
                // Discard run ends with the sequence-done packet itself
                discarding = ~p.meta.seq_done;
            end else begin
                if (hit != c.filter_invert) begin
                    p.meta.dest = c.filter_route;
                    expect_q.push_back(p);
                end
                if (c.break_en && (hit != c.break_invert)) begin
                    discarding = 1'b1;
                end
            end
        end
    endtask

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic report_failure(input string what);
        $display("** Error at time %0t: %s", $time, what);
        errors++;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("** Error at time %0t: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_pkt(input string name, input engine_pkt_s got, input engine_pkt_s exp);
        assert (got === exp) else begin
            $display("** Error at time %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // DUT control
    // --------------------------------------------------
    task automatic reset_dut();
        @(negedge ap_clk);
        areset_generator = 1'b1;
        cfg_valid        = 1'b0;
        pkt_in_valid     = 1'b0;
        pkt_out_ready    = 1'b0;
        repeat (4) @(negedge ap_clk);
        areset_generator = 1'b0;
    endtask

    task automatic configure_dut(input filter_cfg_s c);
        int cycles;
        cycles    = 0;
        cfg_data  = c;
        cfg_valid = 1'b1;
        while (!cfg_ready && cycles < wait_limit) begin
            @(negedge ap_clk);
            cycles++;
        end
        assert (cycles < wait_limit) else report_failure("cfg_ready never rose");
        @(negedge ap_clk);
        cfg_valid = 1'b0;
        check_bit("cfg_ready", cfg_ready, 1'b0);
    endtask

    // Inputs driven and transfers predicted at each falling edge
    task automatic run_stream(input logic stall_out);
        int   idx;
        int   quiet;
        int   cycles;
        logic finished;
        idx        = 0;
        quiet      = 0;
        cycles     = 0;
        finished   = 1'b0;
        stall_seen = 1'b0;
        got_q.delete();
        while (!finished && cycles < wait_limit) begin
            // Done only counts two cycles after the last push
            finished = (idx == send_q.size()) && (quiet >= 2) && done
                       && (got_q.size() >= expect_q.size());
            if (!finished) begin
                pkt_in_valid  = (idx < send_q.size());
                pkt_in_data   = pkt_in_valid ? send_q[idx] : '0;
                pkt_out_ready = !stall_out || stall_seen;
                if (pkt_in_valid && pkt_in_ready) begin
                    idx++;
                    quiet = 0;
                end else begin
                    quiet++;
                end
                if (pkt_in_valid && !pkt_in_ready) begin
                    stall_seen = 1'b1;
                end
                if (pkt_out_valid && pkt_out_ready) begin
                    got_q.push_back(pkt_out_data);
                end
                @(negedge ap_clk);
                cycles++;
            end
        end
        pkt_in_valid = 1'b0;
        assert (finished) else report_failure("stream did not drain and raise done in time");
        assert (got_q.size() == expect_q.size()) else begin
            $display("** Error at time %0t: pkt_out count = %0d, expected %0d",
                     $time, got_q.size(), expect_q.size());
            errors++;
        end
        foreach (got_q[i]) begin
            if (i < expect_q.size()) begin
                check_pkt($sformatf("pkt_out_data[%0d]", i), got_q[i], expect_q[i]);
            end
        end
    endtask

    task automatic run_case(input filter_cfg_s c, input logic stall_out);
        reset_dut();
        configure_dut(c);
        build_expected(c);
        run_stream(stall_out);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic reset_and_config();
        int cycles;
        reset_dut();
        check_bit("cfg_ready", cfg_ready, 1'b1);
        check_bit("done", done, 1'b0);
        check_bit("pkt_out_valid", pkt_out_valid, 1'b0);
        check_bit("pkt_in_ready", pkt_in_ready, 1'b0);
        configure_dut(make_cfg(cmp_eq, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0));
        check_bit("pkt_in_ready", pkt_in_ready, 1'b1);
        cycles = 0;
        while (!done && cycles < wait_limit) begin
            @(negedge ap_clk);
            cycles++;
        end
        assert (done) else report_failure("done did not rise after configuration");
    endtask

    task automatic unsigned_filtering();
        filter_cfg_s c;
        logic [31:0] r;
        send_q.delete();
        for (int i = 0; i < 20; i++) begin
            take_random(32, r);
            add_packet(r, i == 19);
        end
        c = make_cfg(cmp_lt, 1'b0, 32'h8000_0000, 1'b0, 1'b0, 1'b0);
        run_case(c, 1'b0);
        // Complement set
        c.filter_invert = 1'b1;
        run_case(c, 1'b0);
        c = make_cfg(cmp_eq, 1'b0, send_q[7].data.u, 1'b1, 1'b0, 1'b0);
        run_case(c, 1'b0);
    endtask

    task automatic signed_compare();
        logic [31:0] words [8] = '{32'hffff_ffff, 32'h8000_0000, 32'hffff_f000,
                                   32'hffff_ff00, 32'h0000_0010, 32'h7fff_ffff,
                                   32'hffff_fc18, 32'hffff_fc19};
        logic [31:0] r;
        send_q.delete();
        foreach (words[i]) begin
            add_packet(words[i], 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            take_random(32, r);
            add_packet(r, 1'b0);
        end
        // Constant is -1000
        run_case(make_cfg(cmp_gt, 1'b1, 32'hffff_fc18, 1'b0, 1'b0, 1'b0), 1'b0);
    endtask

    task automatic break_flow();
        logic [31:0] words [9] = '{32'd5000, 32'd6000, 32'd10, 32'd7000, 32'd8000,
                                   32'd9000, 32'd7100, 32'd7200, 32'd30};
        send_q.delete();
        foreach (words[i]) begin
            add_packet(words[i], (i == 5) || (i == 8));
        end
        // Keep at or above 1000, break below it
        run_case(make_cfg(cmp_lt, 1'b0, 32'd1000, 1'b1, 1'b1, 1'b0), 1'b0);
        foreach (got_q[i]) begin
            assert (got_q[i].meta.seq_id < 3 || got_q[i].meta.seq_id > 5)
            else report_failure("a packet inside the break run came out");
        end
    endtask

    task automatic back_pressure();
        logic [31:0] r;
        send_q.delete();
        for (int i = 0; i < 40; i++) begin
            take_random(32, r);
            add_packet(r, 1'b0);
        end
        run_case(make_cfg(cmp_ne, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0), 1'b1);
        assert (stall_seen) else report_failure("pkt_in_ready never fell under back-pressure");
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int mark;
        areset_generator = 1'b1;
        cfg_valid        = 1'b0;
        cfg_data         = '0;
        pkt_in_valid     = 1'b0;
        pkt_in_data      = '0;
        pkt_out_ready    = 1'b0;
        lfsr_state       = 16'd48333;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        mark = errors;
        reset_and_config();
        finish_test("reset and configuration", mark);
        mark = errors;
        unsigned_filtering();
        finish_test("unsigned filtering", mark);
        mark = errors;
        signed_compare();
        finish_test("signed compare", mark);
        mark = errors;
        break_flow();
        finish_test("break flow", mark);
        mark = errors;
        back_pressure();
        finish_test("back-pressure", mark);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : glay_filter_tb

/* glay_filter.f */
common/glay_filter_pkg.sv
logic/packet_fifo.sv
logic/filter_engine_ctrl.sv
filter_pipeline/filter_cond_alu.sv
filter_pipeline/filter_flow_stage.sv
logic/glay_filter_engine.sv
verification/glay_filter_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := glay_filter_tb
RTL_TOP    := glay_filter_engine
FILELIST   := glay_filter.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
